// File: design/isa_pkg.sv
package isa_pkg;

  typedef logic [31:0] word_t;      // data, address or instruction word
  typedef logic [4:0]  reg_addr_t;  // register index
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;

  // major opcodes of the supported subset
  localparam opcode_t OP_RTYPE = 7'b0110011;
  localparam opcode_t OP_ITYPE = 7'b0010011;
  localparam opcode_t OP_LOAD  = 7'b0000011;
  localparam opcode_t OP_STORE = 7'b0100011;

  localparam funct3_t FUNCT3_ADD = 3'b000;  // also sub, lw, sw
  localparam funct3_t FUNCT3_SLT = 3'b010;
  localparam funct3_t FUNCT3_XOR = 3'b100;
  localparam funct3_t FUNCT3_OR  = 3'b110;
  localparam funct3_t FUNCT3_AND = 3'b111;

  localparam int FUNCT7_SUB_BIT = 30;  // instr[30] turns add into sub

  // lsb positions of the instruction fields
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int IMM_I_LSB  = 20;
  localparam int IMM_S_HI   = 25;  // s-format imm[11:5] starts here

  localparam int DMEM_WORDS = 64;

endpackage

// File: design/pipe_pkg.sv
package pipe_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  // source of an execute operand
  typedef enum logic [1:0] {
    FWD_REG,  // value read from the register file in q2
    FWD_Q4,   // alu result one stage ahead
    FWD_Q5    // write-back value two stages ahead
  } fwd_sel_e;

  typedef logic [4:0] ctrl_t;

  // bit positions inside ctrl_t
  localparam int CTRL_ALUSRC_IMM = 4;
  localparam int CTRL_MEM_REN    = 3;
  localparam int CTRL_MEM_WREN   = 2;
  localparam int CTRL_REG_WR_EN  = 1;
  localparam int CTRL_MEM_TO_REG = 0;

endpackage

// File: design/decoder.sv
`timescale 1ns/10ps

module decoder
  import isa_pkg::*, pipe_pkg::*;
(
  input  word_t   instr_i,
  output ctrl_t   ctrl_o,
  output alu_op_e alu_op_o,
  output word_t   imm_o
);

  opcode_t opcode;
  funct3_t funct3;
  logic    is_store;

  assign opcode   = instr_i[6:0];
  assign funct3   = instr_i[FUNCT3_LSB +: 3];
  assign is_store = (opcode == OP_STORE);

  // s-format splits imm[11:0] around rd
  assign imm_o = is_store ?
                 {{20{instr_i[31]}}, instr_i[31:IMM_S_HI], instr_i[RD_LSB +: 5]} :
                 {{20{instr_i[31]}}, instr_i[31:IMM_I_LSB]};

  always_comb begin
    ctrl_o = '0;  // unknown opcode acts as a bubble
    case (opcode)
      OP_RTYPE: ctrl_o[CTRL_REG_WR_EN] = 1'b1;
      OP_ITYPE: begin
        ctrl_o[CTRL_ALUSRC_IMM] = 1'b1;
        ctrl_o[CTRL_REG_WR_EN]  = 1'b1;
      end
      OP_LOAD: begin
        ctrl_o[CTRL_ALUSRC_IMM] = 1'b1;
        ctrl_o[CTRL_MEM_REN]    = 1'b1;
        ctrl_o[CTRL_REG_WR_EN]  = 1'b1;
        ctrl_o[CTRL_MEM_TO_REG] = 1'b1;
      end
      OP_STORE: begin
        ctrl_o[CTRL_ALUSRC_IMM] = 1'b1;
        ctrl_o[CTRL_MEM_WREN]   = 1'b1;
      end
      default: ctrl_o = '0;
    endcase
  end

  always_comb begin
    alu_op_o = ALU_ADD;  // address add for lw and sw
    if (opcode == OP_RTYPE || opcode == OP_ITYPE) begin
      case (funct3)
        FUNCT3_ADD: begin
          // only the r-type form has a sub, addi uses bit 30 as immediate
          if (opcode == OP_RTYPE && instr_i[FUNCT7_SUB_BIT]) alu_op_o = ALU_SUB;
        end
        FUNCT3_SLT: alu_op_o = ALU_SLT;
        FUNCT3_XOR: alu_op_o = ALU_XOR;
        FUNCT3_OR:  alu_op_o = ALU_OR;
        FUNCT3_AND: alu_op_o = ALU_AND;
        default:    alu_op_o = ALU_ADD;
      endcase
    end
  end

endmodule

// File: design/regfile.sv
`timescale 1ns/10ps

module regfile
  import isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  reg_addr_t rd_i,
  input  word_t     wr_data_i,
  input  logic      wr_en_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o
);

  word_t regs [1:31];  // x0 has no storage
  logic  wr_live;

  assign wr_live = wr_en_i && (rd_i != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (wr_live) begin
      regs[rd_i] <= wr_data_i;
    end
  end

  // write-first: q2 sees the value q5 retires in the same cycle
  assign rs1_data_o = (rs1_i == '0)                  ? '0        :
                      (wr_live && rd_i == rs1_i)     ? wr_data_i : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0)                  ? '0        :
                      (wr_live && rd_i == rs2_i)     ? wr_data_i : regs[rs2_i];

endmodule

// File: design/execute.sv
`timescale 1ns/10ps

module execute
  import isa_pkg::*, pipe_pkg::*;
(
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  word_t     rs1_data_i,
  input  word_t     rs2_data_i,
  input  word_t     imm_i,
  input  ctrl_t     ctrl_i,
  input  alu_op_e   alu_op_i,
  input  reg_addr_t q4_rd_i,
  input  logic      q4_wr_en_i,   // valid and writes a register
  input  logic      q4_is_load_i,
  input  word_t     q4_result_i,
  input  reg_addr_t q5_rd_i,
  input  logic      q5_wr_en_i,
  input  word_t     q5_result_i,
  output word_t     alu_result_o,
  output word_t     store_data_o
);

  fwd_sel_e sel_op1;
  fwd_sel_e sel_op2;
  fwd_sel_e sel_st;
  logic     q4_fwd_ok;
  word_t    op1;
  word_t    rs2_fwd;
  word_t    op2;

  assign q4_fwd_ok = q4_wr_en_i && !q4_is_load_i;  // load data not ready until q5

  // q4 is the most recent producer, so it is checked first
  function automatic fwd_sel_e pick_fwd(input reg_addr_t rs, input logic used,
                                        input logic q4_ok, input reg_addr_t q4_rd,
                                        input logic q5_ok, input reg_addr_t q5_rd);
    fwd_sel_e sel;
    sel = FWD_REG;
    if (used && rs != '0) begin
      if (q4_ok && q4_rd == rs) sel = FWD_Q4;
      else if (q5_ok && q5_rd == rs) sel = FWD_Q5;
    end
    return sel;
  endfunction

  function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                    input word_t q4_val, input word_t q5_val);
    word_t val;
    case (sel)
      FWD_Q4:  val = q4_val;
      FWD_Q5:  val = q5_val;
      default: val = reg_val;
    endcase
    return val;
  endfunction

  assign sel_op1 = pick_fwd(rs1_i, 1'b1, q4_fwd_ok, q4_rd_i, q5_wr_en_i, q5_rd_i);
  // i-type has no rs2
  assign sel_op2 = pick_fwd(rs2_i, !ctrl_i[CTRL_ALUSRC_IMM], q4_fwd_ok, q4_rd_i,
                            q5_wr_en_i, q5_rd_i);
  assign sel_st  = pick_fwd(rs2_i, ctrl_i[CTRL_MEM_WREN], q4_fwd_ok, q4_rd_i,
                            q5_wr_en_i, q5_rd_i);

  assign op1          = fwd_mux(sel_op1, rs1_data_i, q4_result_i, q5_result_i);
  assign rs2_fwd      = fwd_mux(sel_op2, rs2_data_i, q4_result_i, q5_result_i);
  assign op2          = ctrl_i[CTRL_ALUSRC_IMM] ? imm_i : rs2_fwd;
  assign store_data_o = fwd_mux(sel_st, rs2_data_i, q4_result_i, q5_result_i);

  always_comb begin
    case (alu_op_i)
      ALU_ADD: alu_result_o = op1 + op2;
      ALU_SUB: alu_result_o = op1 - op2;
      ALU_AND: alu_result_o = op1 & op2;
      ALU_OR:  alu_result_o = op1 | op2;
      ALU_XOR: alu_result_o = op1 ^ op2;
      ALU_SLT: alu_result_o = {31'b0, $signed(op1) < $signed(op2)};
      default: alu_result_o = '0;
    endcase
  end

endmodule

// File: design/data_mem.sv
`timescale 1ns/10ps

module data_mem
  import isa_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  ren_i,
  input  logic  wen_i,
  input  word_t addr_i,
  input  word_t wdata_i,
  output word_t rdata_o
);

  localparam int AW = $clog2(DMEM_WORDS);

  word_t          mem [DMEM_WORDS];
  logic  [AW-1:0] idx;

  assign idx = addr_i[AW+1:2];  // word index, byte offset ignored

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DMEM_WORDS; i++) mem[i] <= '0;
    end else if (wen_i) begin
      mem[idx] <= wdata_i;
    end
  end

  assign rdata_o = ren_i ? mem[idx] : '0;

endmodule

// File: design/core_top.sv
`timescale 1ns/10ps

module core_top
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  word_t     imem_rdata_i,
  output word_t     imem_addr_o,
  output logic      wb_valid_o,
  output reg_addr_t wb_rd_o,
  output word_t     wb_data_o
);

  word_t pc;

  // q2 decode and register read
  logic      v_q2;
  word_t     instr_q2;
  ctrl_t     ctrl_dec;
  alu_op_e   alu_op_dec;
  word_t     imm_dec;
  word_t     rs1_data_q2;
  word_t     rs2_data_q2;

  // q3 execute
  logic      v_q3;
  word_t     instr_q3;
  ctrl_t     ctrl_q3;
  alu_op_e   alu_op_q3;
  word_t     imm_q3;
  word_t     rs1_data_q3;
  word_t     rs2_data_q3;
  word_t     alu_result_q3;
  word_t     store_data_q3;

  // q4 memory
  logic      v_q4;
  word_t     instr_q4;
  ctrl_t     ctrl_q4;
  word_t     alu_result_q4;
  word_t     store_data_q4;
  word_t     mem_rdata_q4;
  reg_addr_t rd_q4;

  // q5 write-back
  logic      v_q5;
  word_t     instr_q5;
  ctrl_t     ctrl_q5;
  word_t     alu_result_q5;
  word_t     mem_rdata_q5;
  reg_addr_t rd_q5;
  word_t     wb_data_q5;
  logic      wr_en_q5;

  assign imem_addr_o = pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) pc <= '0;
    else        pc <= pc + 32'd4;  // no branches, straight-line fetch
  end

  // valid bits and control words
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v_q2      <= 1'b0;
      v_q3      <= 1'b0;
      v_q4      <= 1'b0;
      v_q5      <= 1'b0;
      ctrl_q3   <= '0;
      ctrl_q4   <= '0;
      ctrl_q5   <= '0;
      alu_op_q3 <= ALU_ADD;
    end else begin
      v_q2      <= 1'b1;  // fetch is valid from the first cycle
      v_q3      <= v_q2;
      v_q4      <= v_q3;
      v_q5      <= v_q4;
      ctrl_q3   <= v_q2 ? ctrl_dec : '0;
      ctrl_q4   <= ctrl_q3;
      ctrl_q5   <= ctrl_q4;
      alu_op_q3 <= alu_op_dec;
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    instr_q2      <= imem_rdata_i;
    instr_q3      <= instr_q2;
    imm_q3        <= imm_dec;
    rs1_data_q3   <= rs1_data_q2;
    rs2_data_q3   <= rs2_data_q2;
    instr_q4      <= instr_q3;
    alu_result_q4 <= alu_result_q3;
    store_data_q4 <= store_data_q3;
    instr_q5      <= instr_q4;
    alu_result_q5 <= alu_result_q4;
    mem_rdata_q5  <= mem_rdata_q4;
  end

  assign rd_q4 = instr_q4[RD_LSB +: 5];
  assign rd_q5 = instr_q5[RD_LSB +: 5];

  assign wr_en_q5   = v_q5 && ctrl_q5[CTRL_REG_WR_EN];
  assign wb_data_q5 = ctrl_q5[CTRL_MEM_TO_REG] ? mem_rdata_q5 : alu_result_q5;

  assign wb_valid_o = wr_en_q5 && (rd_q5 != '0);  // x0 writes are not traced
  assign wb_rd_o    = rd_q5;
  assign wb_data_o  = wb_data_q5;

  decoder u_decoder (
    .instr_i  (instr_q2),
    .ctrl_o   (ctrl_dec),
    .alu_op_o (alu_op_dec),
    .imm_o    (imm_dec)
  );

  regfile u_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .rs1_i      (instr_q2[RS1_LSB +: 5]),
    .rs2_i      (instr_q2[RS2_LSB +: 5]),
    .rd_i       (rd_q5),
    .wr_data_i  (wb_data_q5),
    .wr_en_i    (wr_en_q5),
    .rs1_data_o (rs1_data_q2),
    .rs2_data_o (rs2_data_q2)
  );

  execute u_execute (
    .rs1_i        (instr_q3[RS1_LSB +: 5]),
    .rs2_i        (instr_q3[RS2_LSB +: 5]),
    .rs1_data_i   (rs1_data_q3),
    .rs2_data_i   (rs2_data_q3),
    .imm_i        (imm_q3),
    .ctrl_i       (ctrl_q3),
    .alu_op_i     (alu_op_q3),
    .q4_rd_i      (rd_q4),
    .q4_wr_en_i   (v_q4 && ctrl_q4[CTRL_REG_WR_EN]),
    .q4_is_load_i (ctrl_q4[CTRL_MEM_REN]),  // load data not ready until q5
    .q4_result_i  (alu_result_q4),
    .q5_rd_i      (rd_q5),
    .q5_wr_en_i   (wr_en_q5),
    .q5_result_i  (wb_data_q5),
    .alu_result_o (alu_result_q3),
    .store_data_o (store_data_q3)
  );

  data_mem u_data_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .ren_i   (v_q4 && ctrl_q4[CTRL_MEM_REN]),
    .wen_i   (v_q4 && ctrl_q4[CTRL_MEM_WREN]),
    .addr_i  (alu_result_q4),
    .wdata_i (store_data_q4),
    .rdata_o (mem_rdata_q4)
  );

endmodule

// File: sim/core_tb.sv
`timescale 1ns/10ps

module core_tb
  import isa_pkg::*;
();

  logic      clk;
  logic      rst_n;
  word_t     imem_rdata_i;
  word_t     imem_addr_o;
  logic      wb_valid_o;
  reg_addr_t wb_rd_o;
  word_t     wb_data_o;

  // program table with one instruction and its expected write-back per row
  word_t     prog_instr [32];
  logic      prog_wr    [32];
  reg_addr_t prog_rd    [32];
  word_t     prog_val   [32];
  int        n_rows = 0;

  int cyc        = 0;  // posedges since reset release
  int cyc_limit  = 0;
  int pass_count = 0;
  int fail_count = 0;

  core_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_rdata_i (imem_rdata_i),
    .imem_addr_o  (imem_addr_o),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o)
  );

  always #2 clk = ~clk;

  function automatic word_t encode_r(bit sub, funct3_t f3, reg_addr_t rd, reg_addr_t rs1,
                                     reg_addr_t rs2);
    return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, OP_RTYPE};
  endfunction

  function automatic word_t encode_i(opcode_t op, funct3_t f3, reg_addr_t rd, reg_addr_t rs1,
                                     int imm);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic word_t encode_s(reg_addr_t rs2, reg_addr_t rs1, int imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};  // funct3 of sw
  endfunction

  task automatic add_row(word_t instr, logic wr, reg_addr_t rd, word_t val);
    prog_instr[n_rows] = instr;
    prog_wr[n_rows]    = wr;
    prog_rd[n_rows]    = rd;
    prog_val[n_rows]   = val;
    n_rows++;
  endtask

  // instruction memory holds addi x0,x0,0 past the table
  function automatic word_t fetch_word(word_t addr);
    int idx;
    idx = addr >> 2;
    if (idx < n_rows) return prog_instr[idx];
    return encode_i(OP_ITYPE, FUNCT3_ADD, 5'd0, 5'd0, 0);
  endfunction

  task automatic check_value(string what, word_t got, word_t exp);
    if (got === exp) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("Fail %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // pc starts at 0 and steps one word per cycle
  always @(negedge clk) begin
    if (rst_n) check_value("fetch address", imem_addr_o, cyc * 4);
    imem_rdata_i <= fetch_word(imem_addr_o);
  end

  always @(posedge clk) begin
    if (rst_n) cyc <= cyc + 1;
    if (rst_n && cyc >= cyc_limit) begin
      $display("timeout: no end of run after %0d cycles", cyc_limit);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    int errs_before;
    clk   = 1'b0;
    rst_n = 1'b0;
    imem_rdata_i = encode_i(OP_ITYPE, FUNCT3_ADD, 5'd0, 5'd0, 0);

    add_row(encode_i(OP_ITYPE, FUNCT3_ADD, 5'd1, 5'd0, 5),       1, 5'd1, 32'd5);
    add_row(encode_i(OP_ITYPE, FUNCT3_ADD, 5'd2, 5'd0, -3),      1, 5'd2, 32'hffff_fffd);
    add_row(encode_i(OP_ITYPE, FUNCT3_ADD, 5'd3, 5'd0, 'h7f0),   1, 5'd3, 32'h7f0);
    add_row(encode_r(1, FUNCT3_ADD, 5'd4, 5'd1, 5'd2),           1, 5'd4, 32'd8);
    add_row(encode_r(0, FUNCT3_SLT, 5'd5, 5'd2, 5'd1),           1, 5'd5, 32'd1);  // -3 < 5
    add_row(encode_r(0, FUNCT3_OR,  5'd6, 5'd4, 5'd3),           1, 5'd6, 32'h7f8);
    add_row(encode_i(OP_ITYPE, FUNCT3_ADD, 5'd7, 5'd6, 1),       1, 5'd7, 32'h7f9);
    add_row(encode_r(0, FUNCT3_XOR, 5'd8, 5'd1, 5'd7),           1, 5'd8, 32'h7fc);
    add_row(encode_r(0, FUNCT3_AND, 5'd9, 5'd8, 5'd7),           1, 5'd9, 32'h7f8);
    add_row(encode_i(OP_ITYPE, FUNCT3_ADD, 5'd9, 5'd9, -8),      1, 5'd9, 32'h7f0);
    add_row(encode_r(0, FUNCT3_ADD, 5'd10, 5'd9, 5'd9),          1, 5'd10, 32'hfe0);
    add_row(encode_i(OP_ITYPE, FUNCT3_SLT, 5'd11, 5'd2, -2),     1, 5'd11, 32'd1);
    add_row(encode_i(OP_ITYPE, FUNCT3_OR,  5'd12, 5'd0, -1),     1, 5'd12, 32'hffff_ffff);
    add_row(encode_i(OP_ITYPE, FUNCT3_AND, 5'd13, 5'd12, 'h0f0), 1, 5'd13, 32'hf0);
    add_row(encode_i(OP_ITYPE, FUNCT3_XOR, 5'd14, 5'd12, 'h555), 1, 5'd14, 32'hffff_faaa);
    add_row(encode_r(0, FUNCT3_SLT, 5'd15, 5'd12, 5'd0),         1, 5'd15, 32'd1);
    add_row(encode_i(OP_ITYPE, FUNCT3_ADD, 5'd16, 5'd0, 'h123),  1, 5'd16, 32'h123);
    add_row(encode_s(5'd16, 5'd0, 4),                            0, 5'd0, 32'd0);  // data from q4
    add_row(encode_i(OP_ITYPE, FUNCT3_ADD, 5'd17, 5'd0, 'h456),  1, 5'd17, 32'h456);
    add_row(encode_i(OP_ITYPE, FUNCT3_ADD, 5'd18, 5'd0, 16),     1, 5'd18, 32'd16);
    add_row(encode_s(5'd17, 5'd18, 0),                           0, 5'd0, 32'd0);  // data from q5
    add_row(encode_i(OP_LOAD, 3'b010, 5'd19, 5'd0, 4),           1, 5'd19, 32'h123);
    add_row(encode_i(OP_LOAD, 3'b010, 5'd20, 5'd18, 0),          1, 5'd20, 32'h456);
    add_row(encode_i(OP_ITYPE, FUNCT3_ADD, 5'd0, 5'd0, 7),       0, 5'd0, 32'd0);
    add_row(encode_r(0, FUNCT3_ADD, 5'd21, 5'd19, 5'd20),        1, 5'd21, 32'h579);
    add_row(encode_r(0, FUNCT3_ADD, 5'd22, 5'd0, 5'd1),          1, 5'd22, 32'd5);
    add_row(encode_i(OP_ITYPE, FUNCT3_ADD, 5'd0, 5'd1, 9),       0, 5'd0, 32'd0);
    add_row(encode_r(0, FUNCT3_OR,  5'd23, 5'd0, 5'd0),          1, 5'd23, 32'd0);
    cyc_limit = n_rows + 20;

    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < n_rows; i++) begin
      if (prog_wr[i]) begin
        errs_before = fail_count;
        @(negedge clk);
        while (!wb_valid_o) @(negedge clk);
        check_value($sformatf("row %0d cycle", i), cyc, i + 4);  // write-back 4 after fetch
        check_value($sformatf("row %0d rd", i), wb_rd_o, prog_rd[i]);
        check_value($sformatf("row %0d data", i), wb_data_o, prog_val[i]);
        if (fail_count == errs_before) $display("row %0d: x%0d ok", i, prog_rd[i]);
        else                           $display("row %0d: x%0d wrong", i, prog_rd[i]);
      end else begin
        $display("row %0d: no write-back expected", i);
      end
    end

    // padding nops must stay silent
    repeat (8) begin
      @(negedge clk);
      if (wb_valid_o) begin
        fail_count++;
        $display("unexpected write-back to x%0d after the last row", wb_rd_o);
      end
    end

    $display("%0d checks passed, %0d checks failed", pass_count, fail_count);
    if (fail_count == 0) $display("all tests passed");
    else                 $display("tests failed");
    $finish;
  end

endmodule

// File: project.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/decoder.sv
design/regfile.sv
design/execute.sv
design/data_mem.sv
design/core_top.sv
sim/core_tb.sv

// File: Bender.yml
package:
  name: rv_pipe_core

sources:
  - design/isa_pkg.sv
  - design/pipe_pkg.sv
  - design/decoder.sv
  - design/regfile.sv
  - design/execute.sv
  - design/data_mem.sv
  - design/core_top.sv
  - target: simulation
    files:
      - sim/core_tb.sv
